/* src.f */
verilog/fetch_pkg.sv
verilog/fetch_control.sv
verilog/pc_gen.sv
verilog/ibus_master.sv
verilog/static_predictor.sv
verilog/fetch_ex_latch.sv
verilog/fetch_top.sv
test/tb_imem_model.sv
test/tb_fetch_top.sv

/* Bender.yml */
package:
  name: fetch_top

sources:
  - verilog/fetch_pkg.sv
  - verilog/fetch_control.sv
  - verilog/pc_gen.sv
  - verilog/ibus_master.sv
  - verilog/static_predictor.sv
  - verilog/fetch_ex_latch.sv
  - verilog/fetch_top.sv
  - target: test
    files:
      - test/tb_imem_model.sv
      - test/tb_fetch_top.sv

/* test/tb_fetch_top.sv */
`timescale 1ns/100ps

module tb_fetch_top;

    localparam int               SEED       = 57528;
    localparam int               MEM_AW     = 12;
    localparam int               MEM_WORDS  = 1 << MEM_AW;
    localparam int               WAIT_LIMIT = 400;
    localparam fetch_pkg::word_t ERR_ADDR   = 32'h0000_1090;

    logic                    CLK;
    logic                    nRST;
    fetch_pkg::wb_req_t      wb_req;
    fetch_pkg::wb_rsp_t      wb_rsp;
    fetch_pkg::ex_redirect_t redirect;
    logic                    stall;
    logic                    flush;
    fetch_pkg::fetch_ex_t    fetch_ex;

    fetch_pkg::word_t     prog [MEM_WORDS];
    fetch_pkg::word_t     exp_pc;
    fetch_pkg::fetch_ex_t prev_fex;
    fetch_pkg::word_t     prev_adr;
    logic                 prev_ok;
    logic                 prev_stall;
    logic                 prev_flush;
    logic                 prev_redirect;
    logic                 prev_wait;
    logic                 prev_end;
    int                   errors;
    int                   timeouts;
    int                   items;
    int                   taken_cnt;
    int                   fault_cnt;
    int                   mal_cnt;

    fetch_top i_dut (
        .CLK,
        .nRST,
        .wb_req,
        .wb_rsp,
        .redirect,
        .stall,
        .flush,
        .fetch_ex
    );

    tb_imem_model #(.ERR_ADDR(ERR_ADDR), .AW(MEM_AW)) i_mem (
        .CLK,
        .nRST,
        .wb_req,
        .wb_rsp
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    task automatic report_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors = errors + 1;
    endtask

    // RV32I immediates straight from the bit positions of the ISA
    function automatic fetch_pkg::word_t b_offset(input fetch_pkg::word_t w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic fetch_pkg::word_t j_offset(input fetch_pkg::word_t w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic fetch_pkg::word_t enc_branch(input logic [2:0] f3, input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic fetch_pkg::word_t enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
    endfunction

    // addi with an immediate taken from the word index
    function automatic fetch_pkg::word_t fill_word(input fetch_pkg::word_t a);
        return {a[13:2], 5'd0, 3'b000, a[6:2], 7'b0010011};
    endfunction

    task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = fill_word(i * 4);
        end
        // Forward beq that falls through
        prog[12'h403] = enc_branch(3'b000, 13'd16);
        // jal 0x1010 -> 0x1040
        prog[12'h404] = enc_jal(21'h30);
        // Backward blt 0x1048 -> 0x1018
        prog[12'h412] = enc_branch(3'b100, -13'd48);
        // jal 0x101c -> 0x1080 and straight code into the error address
        prog[12'h407] = enc_jal(21'h64);
        for (int i = 0; i < MEM_WORDS; i++) begin
            i_mem.mem[i] = prog[i];
        end
    endtask

    task automatic check_item();
        fetch_pkg::word_t w;
        fetch_pkg::word_t nxt;
        logic             taken;
        items = items + 1;
        nxt   = exp_pc + 32'd4;
        taken = 1'b0;
        assert (fetch_ex.pc == exp_pc)
            else report_mismatch($sformatf("pc %h, expected %h", fetch_ex.pc, exp_pc));
        assert (fetch_ex.pc4 == exp_pc + 32'd4)
            else report_mismatch($sformatf("pc4 %h for expected pc %h", fetch_ex.pc4, exp_pc));
        if (exp_pc[1:0] != 2'b00) begin
            mal_cnt = mal_cnt + 1;
            assert (fetch_ex.mal_insn && !fetch_ex.fault_insn && fetch_ex.instr == '0)
                else report_mismatch($sformatf("no misaligned slot at %h", exp_pc));
        end else if (exp_pc == ERR_ADDR) begin
            fault_cnt = fault_cnt + 1;
            assert (fetch_ex.fault_insn && !fetch_ex.mal_insn && fetch_ex.instr == '0)
                else report_mismatch($sformatf("no bus fault slot at %h", exp_pc));
        end else begin
            w = prog[exp_pc[MEM_AW+1:2]];
            assert (fetch_ex.instr == w && !fetch_ex.fault_insn && !fetch_ex.mal_insn)
                else report_mismatch($sformatf("instr %h at %h, expected %h",
                                               fetch_ex.instr, exp_pc, w));
            if (w[6:0] == 7'b1101111) begin
                taken = 1'b1;
                nxt   = exp_pc + j_offset(w);
            end else if (w[6:0] == 7'b1100011 && w[31]) begin
                taken = 1'b1;
                nxt   = exp_pc + b_offset(w);
            end
        end
        assert (fetch_ex.prediction == taken)
            else report_mismatch($sformatf("prediction %b at %h", fetch_ex.prediction, exp_pc));
        if (taken) begin
            taken_cnt = taken_cnt + 1;
            assert (fetch_ex.predicted_address == nxt)
                else report_mismatch($sformatf("target %h, expected %h",
                                               fetch_ex.predicted_address, nxt));
        end
        exp_pc = nxt;
    endtask

    // Sampled at the rising edge before the DUT updates
    always @(posedge CLK) begin : check_outputs
        if (!nRST) begin
            assert (!wb_req.cyc && !wb_req.stb && !fetch_ex.valid)
                else report_mismatch("bus or fetch_ex active during reset");
            prev_ok = 1'b0;
        end else begin
            assert (!(wb_req.stb && wb_req.adr[1:0] != 2'b00))
                else report_mismatch($sformatf("stb with misaligned adr %h", wb_req.adr));
            assert (!wb_req.stb || (wb_req.cyc && !wb_req.we && wb_req.sel == 4'hf))
                else report_mismatch("stb without cyc or not a full word read");
            if (prev_ok && prev_wait) begin
                assert (wb_req.stb && wb_req.adr == prev_adr)
                    else report_mismatch("bus request changed before ack or err");
            end
            if (prev_ok && prev_end) begin
                assert (!wb_req.cyc && !wb_req.stb)
                    else report_mismatch("bus request not dropped after ack or err");
            end
            if (prev_ok && prev_stall && !prev_redirect) begin
                assert (fetch_ex == prev_fex)
                    else report_mismatch("fetch_ex changed under stall");
            end
            if (prev_ok && ((prev_flush && !prev_stall) || prev_redirect)) begin
                assert (!fetch_ex.valid)
                    else report_mismatch("fetch_ex still valid after flush or redirect");
            end
            if (fetch_ex.valid && (!prev_fex.valid || fetch_ex.pc != prev_fex.pc)) begin
                check_item();
            end
            // New path starts after the word already in the latch
            if (redirect.valid) begin
                exp_pc = redirect.target;
            end
            prev_ok = 1'b1;
        end
        prev_fex      = fetch_ex;
        prev_stall    = stall;
        prev_flush    = flush;
        prev_redirect = redirect.valid;
        prev_wait     = wb_req.stb && !wb_rsp.ack && !wb_rsp.err;
        prev_end      = wb_req.stb && (wb_rsp.ack || wb_rsp.err);
        prev_adr      = wb_req.adr;
    end

    task automatic wait_items(input int n);
        int target;
        int cycles;
        target = items + n;
        cycles = 0;
        while (items < target && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        if (items < target) begin
            $display("Timeout: fewer than %0d new instructions after %0d cycles", n, cycles);
            timeouts = timeouts + 1;
        end
    endtask

    task automatic wait_bus_busy();
        int cycles;
        cycles = 0;
        while (!(wb_req.stb && !wb_rsp.ack && !wb_rsp.err) && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("Timeout: no bus cycle started within %0d cycles", cycles);
            timeouts = timeouts + 1;
        end
    endtask

    task automatic wait_misaligned();
        int cycles;
        cycles = 0;
        while (!(fetch_ex.valid && fetch_ex.mal_insn) && cycles < WAIT_LIMIT) begin
            @(posedge CLK);
            #1;
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("Timeout: misaligned redirect never reached fetch_ex");
            timeouts = timeouts + 1;
        end
    endtask

    // One cycle pulse starting 1 ns past an edge
    task automatic drive_redirect(input fetch_pkg::word_t target);
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(posedge CLK);
        #1;
        redirect = '0;
    endtask

    initial begin : stimulus
        int seed_draw;
        errors    = 0;
        timeouts  = 0;
        items     = 0;
        taken_cnt = 0;
        fault_cnt = 0;
        mal_cnt   = 0;
        prev_ok   = 1'b0;
        prev_fex  = '0;
        exp_pc    = fetch_pkg::RESET_PC;
        nRST      = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        redirect  = '0;
        seed_draw = $urandom(SEED);
        build_program();
        repeat (4) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // Straight code, both branch kinds, JAL and the bus error
        wait_items(24);

        // Random back-pressure and one long stall
        repeat (80) begin
            @(posedge CLK);
            #1;
            stall = ($urandom % 3) == 0;
        end
        stall = 1'b1;
        repeat (12) @(posedge CLK);
        #1;
        stall = 1'b0;
        wait_items(4);

        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        wait_items(4);

        // Redirect with a bus cycle in flight
        wait_bus_busy();
        @(posedge CLK);
        #1;
        drive_redirect(32'h0000_2000);
        wait_items(6);

        drive_redirect(32'h0000_2102);
        wait_misaligned();
        drive_redirect(32'h0000_2200);
        wait_items(8);

        if (taken_cnt == 0 || fault_cnt == 0 || mal_cnt == 0) begin
            $display("Not every fetch case was reached by the stimulus");
            errors = errors + 1;
        end
        $display("items %0d, taken %0d, faults %0d, misaligned %0d, errors %0d, timeouts %0d",
                 items, taken_cnt, fault_cnt, mal_cnt, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/tb_imem_model.sv */
`timescale 1ns/100ps

module tb_imem_model #(
    parameter logic [31:0] ERR_ADDR = 32'h0,
    parameter int          AW       = 12
) (
    input  logic               CLK,
    input  logic               nRST,
    input  fetch_pkg::wb_req_t wb_req,
    output fetch_pkg::wb_rsp_t wb_rsp
);

    logic [31:0] mem [2**AW];
    logic        active;
    logic [1:0]  wait_cnt;
    logic        hit;

    // Extra wait states for one bus cycle
    function automatic logic [1:0] draw_delay();
        logic [31:0] r;
        r = $urandom;
        return r[1:0];
    endfunction

    // Terminate once the drawn wait states have passed
    assign hit = wb_req.cyc && wb_req.stb && active && (wait_cnt == 2'd0);

    assign wb_rsp.ack = hit && (wb_req.adr != ERR_ADDR);
    assign wb_rsp.err = hit && (wb_req.adr == ERR_ADDR);
    assign wb_rsp.dat = hit ? mem[wb_req.adr[AW+1:2]] : '0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (hit) begin
            active <= 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!active) begin
                active   <= 1'b1;
                wait_cnt <= draw_delay();
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* verilog/fetch_top.sv */
`timescale 1ns/100ps

module fetch_top (
    input  logic                    CLK,
    input  logic                    nRST,
    output fetch_pkg::wb_req_t      wb_req,
    input  fetch_pkg::wb_rsp_t      wb_rsp,
    input  fetch_pkg::ex_redirect_t redirect,
    input  logic                    stall,
    input  logic                    flush,
    output fetch_pkg::fetch_ex_t    fetch_ex
);

    logic             bus_idle;
    logic             rsp_valid;
    logic             rsp_err;
    logic             rsp_take;
    logic             issue;
    logic             pc_en;
    logic             latch_load;
    logic             latch_squash;
    logic             pc_misaligned;
    logic             predict_taken;
    fetch_pkg::word_t pc;
    fetch_pkg::word_t pc4;
    fetch_pkg::word_t rsp_data;
    fetch_pkg::word_t predict_target;

    fetch_control i_control (
        .CLK,
        .nRST,
        .stall,
        .flush,
        .redirect,
        .bus_idle,
        .rsp_valid,
        .pc_misaligned,
        .rsp_take,
        .issue,
        .pc_en,
        .latch_load,
        .latch_squash
    );

    pc_gen i_pc_gen (
        .CLK,
        .nRST,
        .pc_en,
        .redirect,
        .predict_taken,
        .predict_target,
        .pc,
        .pc4,
        .pc_misaligned
    );

    ibus_master i_ibus (
        .CLK,
        .nRST,
        .issue,
        .addr(pc),
        .rsp_take,
        .wb_req,
        .wb_rsp,
        .bus_idle,
        .rsp_valid,
        .rsp_err,
        .rsp_data
    );

    // Error responses carry no instruction to predict on
    static_predictor i_predictor (
        .instr(rsp_data),
        .pc,
        .rsp_valid(rsp_valid && !rsp_err),
        .predict_taken,
        .predict_target
    );

    fetch_ex_latch i_latch (
        .CLK,
        .nRST,
        .load(latch_load),
        .squash(latch_squash),
        .flush,
        .stall,
        .instr(rsp_data),
        .pc,
        .pc4,
        .predict_taken,
        .predict_target,
        .bus_err(rsp_err),
        .mal(pc_misaligned),
        .fetch_ex
    );

endmodule

/* verilog/fetch_ex_latch.sv */
`timescale 1ns/100ps

module fetch_ex_latch (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 load,
    input  logic                 squash,
    input  logic                 flush,
    input  logic                 stall,
    input  fetch_pkg::word_t     instr,
    input  fetch_pkg::word_t     pc,
    input  fetch_pkg::word_t     pc4,
    input  logic                 predict_taken,
    input  fetch_pkg::word_t     predict_target,
    input  logic                 bus_err,
    input  logic                 mal,
    output fetch_pkg::fetch_ex_t fetch_ex
);

    logic             valid_q;
    logic             pred_q;
    logic             fault_q;
    logic             mal_q;
    fetch_pkg::word_t instr_q;
    fetch_pkg::word_t pc_q;
    fetch_pkg::word_t pc4_q;
    fetch_pkg::word_t target_q;
    logic             take;

    assign take = load && !stall;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= 1'b0;
            pred_q  <= 1'b0;
            fault_q <= 1'b0;
            mal_q   <= 1'b0;
        end else if ((flush && !stall) || squash) begin
            valid_q <= 1'b0;
            pred_q  <= 1'b0;
            fault_q <= 1'b0;
            mal_q   <= 1'b0;
        end else if (take) begin
            // Faulting slots stay valid so execute can trap
            valid_q <= 1'b1;
            pred_q  <= predict_taken;
            fault_q <= bus_err;
            mal_q   <= mal;
        end
    end

    always_ff @(posedge CLK) begin
        if (take) begin
            instr_q  <= (bus_err || mal) ? '0 : instr;
            pc_q     <= pc;
            pc4_q    <= pc4;
            target_q <= predict_target;
        end
    end

    assign fetch_ex.valid             = valid_q;
    assign fetch_ex.instr             = instr_q;
    assign fetch_ex.pc                = pc_q;
    assign fetch_ex.pc4               = pc4_q;
    assign fetch_ex.prediction        = pred_q;
    assign fetch_ex.predicted_address = target_q;
    assign fetch_ex.fault_insn        = fault_q;
    assign fetch_ex.mal_insn          = mal_q;

endmodule

/* verilog/static_predictor.sv */
`timescale 1ns/100ps

module static_predictor (
    input  fetch_pkg::word_t instr,
    input  fetch_pkg::word_t pc,
    input  logic             rsp_valid,
    output logic             predict_taken,
    output fetch_pkg::word_t predict_target
);

    fetch_pkg::instr_u iw;
    fetch_pkg::word_t  imm_b;
    fetch_pkg::word_t  imm_j;
    logic              is_branch;
    logic              is_jal;

    assign iw.raw = instr;

    assign is_branch = iw.sb.opcode == fetch_pkg::OPC_BRANCH;
    assign is_jal    = iw.uj.opcode == fetch_pkg::OPC_JAL;

    // Sign extended B immediate
    assign imm_b = {{19{iw.sb.imm12}}, iw.sb.imm12, iw.sb.imm11,
                    iw.sb.imm10_05, iw.sb.imm04_01, 1'b0};

    // Sign extended J immediate
    assign imm_j = {{11{iw.uj.imm20}}, iw.uj.imm20, iw.uj.imm19_12,
                    iw.uj.imm11, iw.uj.imm10_01, 1'b0};

    // Backward branches and every JAL are taken
    assign predict_taken = rsp_valid && (is_jal || (is_branch && iw.sb.imm12));

    assign predict_target = pc + (is_jal ? imm_j : imm_b);

endmodule

/* verilog/ibus_master.sv */
`timescale 1ns/100ps

module ibus_master (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               issue,
    input  fetch_pkg::word_t   addr,
    input  logic               rsp_take,
    output fetch_pkg::wb_req_t wb_req,
    input  fetch_pkg::wb_rsp_t wb_rsp,
    output logic               bus_idle,
    output logic               rsp_valid,
    output logic               rsp_err,
    output fetch_pkg::word_t   rsp_data
);

    logic             busy_q;
    fetch_pkg::word_t adr_q;
    logic             rsp_valid_q;
    logic             rsp_err_q;
    fetch_pkg::word_t rsp_data_q;
    logic             start;
    logic             done;

    // Request goes out in the issue cycle and comes from the register afterwards
    assign start = issue && !busy_q;

    assign wb_req.cyc = busy_q || start;
    assign wb_req.stb = busy_q || start;
    assign wb_req.we  = 1'b0;
    assign wb_req.sel = 4'hf;
    assign wb_req.adr = busy_q ? adr_q : addr;

    // Termination counts only while strobing
    assign done = wb_req.stb && (wb_rsp.ack || wb_rsp.err);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy_q <= 1'b0;
        end else if (done) begin
            busy_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            adr_q <= addr;
        end
    end

    // One-entry response buffer
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rsp_valid_q <= 1'b0;
        end else if (done) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_take) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (done) begin
            rsp_data_q <= wb_rsp.dat;
            rsp_err_q  <= wb_rsp.err;
        end
    end

    assign bus_idle  = !busy_q;
    assign rsp_valid = rsp_valid_q;
    // Error flag means nothing once the entry is gone
    assign rsp_err   = rsp_valid_q && rsp_err_q;
    assign rsp_data  = rsp_data_q;

endmodule

/* verilog/pc_gen.sv */
`timescale 1ns/100ps

module pc_gen (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    pc_en,
    input  fetch_pkg::ex_redirect_t redirect,
    input  logic                    predict_taken,
    input  fetch_pkg::word_t        predict_target,
    output fetch_pkg::word_t        pc,
    output fetch_pkg::word_t        pc4,
    output logic                    pc_misaligned
);

    fetch_pkg::word_t pc_q;
    fetch_pkg::word_t npc;

    assign pc4 = pc_q + 32'd4;

    // Execute redirect wins over the static prediction
    always_comb begin
        if (redirect.valid) begin
            npc = redirect.target;
        end else if (predict_taken) begin
            npc = predict_target;
        end else begin
            npc = pc4;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect.valid || pc_en) begin
            pc_q <= npc;
        end
    end

    assign pc = pc_q;

    // Only word aligned fetch is supported
    assign pc_misaligned = |pc_q[1:0];

endmodule

/* verilog/fetch_control.sv */
`timescale 1ns/100ps

module fetch_control (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    stall,
    input  logic                    flush,
    input  fetch_pkg::ex_redirect_t redirect,
    input  logic                    bus_idle,
    input  logic                    rsp_valid,
    input  logic                    pc_misaligned,
    output logic                    rsp_take,
    output logic                    issue,
    output logic                    pc_en,
    output logic                    latch_load,
    output logic                    latch_squash
);

    logic run_q;
    logic discard_q;
    logic ready;
    logic stale;
    logic slot_free;
    logic rsp_accept;
    logic mal_accept;

    // Hold off the first request for one cycle after reset release
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // Response in flight belongs to the old path once execute redirects
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            discard_q <= 1'b0;
        end else if (redirect.valid && !bus_idle) begin
            discard_q <= 1'b1;
        end else if (rsp_take) begin
            discard_q <= 1'b0;
        end
    end

    // Execute can take a new word this cycle
    assign ready = !stall && !flush;

    // Buffered word is from the wrong path
    assign stale = discard_q || redirect.valid;

    // Nothing outstanding and the PC is current
    assign slot_free = run_q && bus_idle && !rsp_valid && !discard_q && !redirect.valid;

    // Misaligned PC never reaches the bus
    assign issue      = slot_free && !pc_misaligned;
    assign mal_accept = slot_free && pc_misaligned && ready;

    assign rsp_accept = rsp_valid && !stale && ready;

    // Stale words are drained even under stall
    assign rsp_take = rsp_valid && (stale || ready);

    assign pc_en        = rsp_accept || mal_accept;
    assign latch_load   = rsp_accept || mal_accept;
    assign latch_squash = redirect.valid;

endmodule

/* verilog/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] word_t;

    // First instruction address after reset
    localparam word_t RESET_PC = 32'h0000_1000;

    // RV32I major opcodes used by the static predictor
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;

    // B-type layout
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        logic [6:0] opcode;
    } sbtype_t;

    // J-type layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_01;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } ujtype_t;

    // One fetched word, seen either as a branch or as a jump
    typedef union packed {
        word_t   raw;
        sbtype_t sb;
        ujtype_t uj;
    } instr_u;

    // Wishbone master outputs
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        logic [3:0] sel;
    } wb_req_t;

    // Wishbone slave outputs
    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } ex_redirect_t;

    // Fetch to execute pipeline word
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        word_t pc4;
        logic  prediction;
        word_t predicted_address;
        logic  fault_insn;
        logic  mal_insn;
    } fetch_ex_t;

endpackage
